//--- Makefile
# Verilator build and run of the response steering testbench

VERILATOR ?= verilator
TOP       ?= tb_response_steering
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- accel_cfg_pkg.sv
/* Accelerator sizing package
   Default widths and lane count shared by the response steering blocks */

package accel_cfg_pkg;

	// ----------------------------------------
	// Data path
	// ----------------------------------------

	// One memory word per response beat
	parameter int DEF_DATA_WIDTH = 32;

	// ----------------------------------------
	// Engine lanes
	// ----------------------------------------

	// Vertex engine lanes fed by the response stream
	parameter int DEF_LANES = 8;

	// ----------------------------------------
	// Counters
	// ----------------------------------------

	// Job sizes, beat counters and the drop counter
	// Wide enough for long vertex jobs
	parameter int DEF_CNT_WIDTH = 16;

endpackage

//--- all.f
accel_cfg_pkg.sv
rsp_types_pkg.sv
rsp_if.sv
rsp_ingress.sv
demux_bus.sv
write_ack_collector.sv
lane_job_tracker.sv
response_steering_top.sv
tb_response_steering.sv

//--- demux_bus.sv
/* Registered read data demultiplexer
   Steers each read beat to the lane it names, three register stages deep */

module demux_bus import accel_cfg_pkg::*, rsp_types_pkg::*; #(
	parameter int DATA_WIDTH = DEF_DATA_WIDTH,
	parameter int BUS_WIDTH  = DEF_LANES,
	parameter int SEL_WIDTH  = $clog2(BUS_WIDTH)
) (
	input  logic                  clock,
	input  logic                  rstn,
	rsp_if.sink                   rsp,
	output logic [DATA_WIDTH-1:0] data_out       [0:BUS_WIDTH-1],
	output logic                  data_out_valid [0:BUS_WIDTH-1]
);

	logic                  read_beat;
	logic [SEL_WIDTH-1:0]  sel_latched;
	logic [DATA_WIDTH-1:0] data_latched;
	logic                  valid_latched;
	logic [DATA_WIDTH-1:0] data_lane      [0:BUS_WIDTH-1];
	logic                  data_lane_valid[0:BUS_WIDTH-1];

	// Write completions share the stream
	// Only read beats enter the demux
	assign read_beat = rsp.valid && (rsp.cmd == CMD_READ);

	// ----------------------------------------
	// Latch stage
	// ----------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_latched <= 1'b0;
			sel_latched   <= '0;
		end else begin
			valid_latched <= read_beat;
			sel_latched   <= rsp.lane;
		end
	end

	always_ff @(posedge clock) begin
		data_latched <= rsp.data;
	end

	// ----------------------------------------
	// Lane stage and output register
	// ----------------------------------------

	for (genvar i = 0; i < BUS_WIDTH; i++) begin : g_lane

		// Valid goes to the selected lane only
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				data_lane_valid[i] <= 1'b0;
			end else if (sel_latched == SEL_WIDTH'(i)) begin
				data_lane_valid[i] <= valid_latched;
			end else begin
				data_lane_valid[i] <= 1'b0;
			end
		end

		// Data fans out to every lane
		always_ff @(posedge clock) begin
			data_lane[i] <= data_latched;
		end

		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				data_out_valid[i] <= 1'b0;
			end else begin
				data_out_valid[i] <= data_lane_valid[i];
			end
		end

		always_ff @(posedge clock) begin
			data_out[i] <= data_lane[i];
		end
	end

endmodule

//--- lane_job_tracker.sv
/* Lane job tracker
   Counts read beats and write acks per lane and flags job completion */

module lane_job_tracker import accel_cfg_pkg::*; #(
	parameter int LANES     = DEF_LANES,
	parameter int CNT_WIDTH = DEF_CNT_WIDTH
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 job_start  [0:LANES-1],
	input  logic [CNT_WIDTH-1:0] job_reads  [0:LANES-1],
	input  logic [CNT_WIDTH-1:0] job_writes [0:LANES-1],
	input  logic                 read_beat  [0:LANES-1],
	input  logic                 ack_pulse  [0:LANES-1],
	output logic                 job_done   [0:LANES-1]
);

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		ACTIVE = 2'd1,
		DONE   = 2'd2
	} lane_state_t;

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		lane_state_t          state;
		logic [CNT_WIDTH-1:0] reads_goal;
		logic [CNT_WIDTH-1:0] writes_goal;
		logic [CNT_WIDTH-1:0] read_cnt;
		logic [CNT_WIDTH-1:0] write_cnt;
		logic                 reads_met;
		logic                 writes_met;

		// ----------------------------------------
		// Job size capture
		// ----------------------------------------

		always_ff @(posedge clock) begin
			if (job_start[i]) begin
				reads_goal  <= job_reads[i];
				writes_goal <= job_writes[i];
			end
		end

		assign reads_met  = read_cnt == reads_goal;
		assign writes_met = write_cnt == writes_goal;

		// ----------------------------------------
		// Lane FSM and counters
		// ----------------------------------------

		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				state     <= IDLE;
				read_cnt  <= '0;
				write_cnt <= '0;
			end else if (job_start[i]) begin
				// Restart from any state
				state     <= ACTIVE;
				read_cnt  <= '0;
				write_cnt <= '0;
			end else begin
				case (state)
					ACTIVE: begin
						if (reads_met && writes_met) begin
							state <= DONE;
						end else begin
							// Counters stop at their goals
							if (read_beat[i] && !reads_met) begin
								read_cnt <= read_cnt + 1'b1;
							end
							if (ack_pulse[i] && !writes_met) begin
								write_cnt <= write_cnt + 1'b1;
							end
						end
					end
					// Single cycle of done
					DONE:    state <= IDLE;
					default: state <= IDLE;
				endcase
			end
		end

		assign job_done[i] = state == DONE;
	end

endmodule

//--- response_steering_top.sv
/* Response steering front of the graph accelerator
   Ingress feeds read steering and write collection, the tracker closes jobs */

module response_steering_top import accel_cfg_pkg::*, rsp_types_pkg::*; #(
	parameter int DATA_WIDTH = DEF_DATA_WIDTH,
	parameter int LANES      = DEF_LANES,
	parameter int CNT_WIDTH  = DEF_CNT_WIDTH
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         in_valid,
	input  rsp_cmd_t                     in_cmd,
	input  logic [$clog2(LANES)-1:0]     in_lane,
	input  logic [DATA_WIDTH-1:0]        in_data,
	input  logic                         job_start        [0:LANES-1],
	input  logic [CNT_WIDTH-1:0]         job_reads        [0:LANES-1],
	input  logic [CNT_WIDTH-1:0]         job_writes       [0:LANES-1],
	output logic [DATA_WIDTH-1:0]        lane_data        [0:LANES-1],
	output logic                         lane_data_valid  [0:LANES-1],
	output logic                         lane_write_error [0:LANES-1],
	output logic                         lane_job_done    [0:LANES-1],
	output logic [CNT_WIDTH-1:0]         drop_count
);

	localparam int LANE_WIDTH = $clog2(LANES);

	// Write completions per lane, into the tracker
	logic ack_pulse [0:LANES-1];

	// Registered response stream shared by both consumers
	rsp_if #(
		.DATA_WIDTH(DATA_WIDTH),
		.LANES     (LANES)
	) u_rsp_if ();

	rsp_ingress #(
		.DATA_WIDTH(DATA_WIDTH),
		.LANES     (LANES),
		.CNT_WIDTH (CNT_WIDTH)
	) u_rsp_ingress (
		.clock     (clock),
		.rstn      (rstn),
		.in_valid  (in_valid),
		.in_cmd    (in_cmd),
		.in_lane   (in_lane),
		.in_data   (in_data),
		.rsp       (u_rsp_if),
		.drop_count(drop_count)
	);

	// ----------------------------------------
	// Parallel consumers
	// ----------------------------------------

	demux_bus #(
		.DATA_WIDTH(DATA_WIDTH),
		.BUS_WIDTH (LANES),
		.SEL_WIDTH (LANE_WIDTH)
	) u_demux_bus (
		.clock         (clock),
		.rstn          (rstn),
		.rsp           (u_rsp_if),
		.data_out      (lane_data),
		.data_out_valid(lane_data_valid)
	);

	write_ack_collector #(
		.LANES     (LANES),
		.DATA_WIDTH(DATA_WIDTH)
	) u_write_ack_collector (
		.clock      (clock),
		.rstn       (rstn),
		.rsp        (u_rsp_if),
		.job_start  (job_start),
		.ack_pulse  (ack_pulse),
		.write_error(lane_write_error)
	);

	// Read beats are counted as they leave the demux
	lane_job_tracker #(
		.LANES    (LANES),
		.CNT_WIDTH(CNT_WIDTH)
	) u_lane_job_tracker (
		.clock     (clock),
		.rstn      (rstn),
		.job_start (job_start),
		.job_reads (job_reads),
		.job_writes(job_writes),
		.read_beat (lane_data_valid),
		.ack_pulse (ack_pulse),
		.job_done  (lane_job_done)
	);

endmodule

//--- rsp_if.sv
/* Registered memory response stream
   One beat per cycle while valid is high, no back-pressure */

interface rsp_if import accel_cfg_pkg::*, rsp_types_pkg::*; #(
	parameter int DATA_WIDTH = DEF_DATA_WIDTH,
	parameter int LANES      = DEF_LANES
) ();

	localparam int LANE_WIDTH = $clog2(LANES);

	// Beat strobe
	logic                  valid;
	// Opcode of the beat
	rsp_cmd_t              cmd;
	// Target engine lane
	logic [LANE_WIDTH-1:0] lane;
	// Read data or write status word
	logic [DATA_WIDTH-1:0] data;

	// Ingress side
	modport source (output valid, output cmd, output lane, output data);

	// Demux and write collector both listen here
	modport sink (input valid, input cmd, input lane, input data);

endinterface

//--- rsp_ingress.sv
/* Response ingress stage
   Registers incoming beats, drops malformed ones and counts the drops */

module rsp_ingress import accel_cfg_pkg::*, rsp_types_pkg::*; #(
	parameter int DATA_WIDTH = DEF_DATA_WIDTH,
	parameter int LANES      = DEF_LANES,
	parameter int CNT_WIDTH  = DEF_CNT_WIDTH
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         in_valid,
	input  rsp_cmd_t                     in_cmd,
	input  logic [$clog2(LANES)-1:0]     in_lane,
	input  logic [DATA_WIDTH-1:0]        in_data,
	rsp_if.source                        rsp,
	output logic [CNT_WIDTH-1:0]         drop_count
);

	logic cmd_ok;
	logic lane_ok;
	logic well_formed;
	logic drop_event;

	// ----------------------------------------
	// Beat check
	// ----------------------------------------

	// Only reads and write completions carry meaning
	assign cmd_ok = (in_cmd == CMD_READ) || (in_cmd == CMD_WRITE);

	// Lane index past the last engine
	// Only reachable when LANES is not a power of two
	assign lane_ok = 32'(in_lane) < LANES;

	assign well_formed = cmd_ok && lane_ok;
	assign drop_event  = in_valid && !well_formed;

	// ----------------------------------------
	// Stream register
	// ----------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp.valid <= 1'b0;
			rsp.cmd   <= CMD_NONE;
			rsp.lane  <= '0;
		end else begin
			// Valid is the only gated field
			rsp.valid <= in_valid && well_formed;
			rsp.cmd   <= in_cmd;
			rsp.lane  <= in_lane;
		end
	end

	// Payload follows the input every cycle
	always_ff @(posedge clock) begin
		rsp.data <= in_data;
	end

	// ----------------------------------------
	// Drop counter
	// ----------------------------------------

	// Holds at all ones once full
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			drop_count <= '0;
		end else if (drop_event && (drop_count != {CNT_WIDTH{1'b1}})) begin
			drop_count <= drop_count + 1'b1;
		end
	end

endmodule

//--- rsp_types_pkg.sv
/* Memory response types
   Response opcode and write completion status codes */

package rsp_types_pkg;

	// ----------------------------------------
	// Response opcode
	// ----------------------------------------

	// NONE and RSVD never leave the ingress stage
	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_READ  = 2'd1,
		CMD_WRITE = 2'd2,
		CMD_RSVD  = 2'd3
	} rsp_cmd_t;

	// ----------------------------------------
	// Write completion status
	// ----------------------------------------

	// Status sits in the low bits of the completion data
	parameter int STATUS_WIDTH = 4;

	// Anything other than OK flags a failed write
	parameter logic [STATUS_WIDTH-1:0] STATUS_OK = '0;

endpackage

//--- tb_response_steering.sv
/* Testbench for the response steering front
   Random reads, writes and malformed beats checked by assertions against a model */

module tb_response_steering import accel_cfg_pkg::*, rsp_types_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DATA_WIDTH  = DEF_DATA_WIDTH;
	localparam int CNT_WIDTH   = DEF_CNT_WIDTH;
	// Six lanes leave indices 6 and 7 out of range
	localparam int LANES       = 6;
	localparam int LANE_WIDTH  = $clog2(LANES);
	// Ingress, latch, lane and output registers
	localparam int READ_STAGES = 4;
	localparam int JOB_LIMIT   = 80;
	localparam int ZERO_LIMIT  = 2;

	logic                  clock;
	logic                  rstn;
	logic                  in_valid;
	rsp_cmd_t              in_cmd;
	logic [LANE_WIDTH-1:0] in_lane;
	logic [DATA_WIDTH-1:0] in_data;
	logic                  job_start        [0:LANES-1];
	logic [CNT_WIDTH-1:0]  job_reads        [0:LANES-1];
	logic [CNT_WIDTH-1:0]  job_writes       [0:LANES-1];
	logic [DATA_WIDTH-1:0] lane_data        [0:LANES-1];
	logic                  lane_data_valid  [0:LANES-1];
	logic                  lane_write_error [0:LANES-1];
	logic                  lane_job_done    [0:LANES-1];
	logic [CNT_WIDTH-1:0]  drop_count;

	// Model state
	logic                  rd_valid [0:READ_STAGES-1];
	logic [LANE_WIDTH-1:0] rd_lane  [0:READ_STAGES-1];
	logic [DATA_WIDTH-1:0] rd_data  [0:READ_STAGES-1];
	logic                  wr_valid [0:1];
	logic [LANE_WIDTH-1:0] wr_lane  [0:1];
	logic                  wr_bad   [0:1];
	logic [CNT_WIDTH-1:0]  exp_drops;
	logic                  exp_err    [0:LANES-1];
	logic                  job_active [0:LANES-1];
	logic [CNT_WIDTH-1:0]  goal_reads [0:LANES-1];
	logic [CNT_WIDTH-1:0]  goal_writes[0:LANES-1];
	int                    rd_seen    [0:LANES-1];
	int                    wr_seen    [0:LANES-1];
	logic                  done_due   [0:LANES-1];
	logic                  done_given [0:LANES-1];
	logic                  beat_legal;

	// Flattened views for the checks
	logic [LANES-1:0] valid_vec;
	logic [LANES-1:0] exp_valid_vec;
	logic [LANES-1:0] ack_vec;
	logic [LANES-1:0] exp_ack_vec;
	logic [LANES-1:0] err_vec;
	logic [LANES-1:0] exp_err_vec;
	logic [LANES-1:0] done_vec;
	logic [LANES-1:0] exp_done_vec;

	integer seed;
	int     value_errors;
	int     timeout_errors;
	string  test_name;

	response_steering_top #(
		.DATA_WIDTH(DATA_WIDTH),
		.LANES     (LANES),
		.CNT_WIDTH (CNT_WIDTH)
	) u_response_steering_top (
		.clock           (clock),
		.rstn            (rstn),
		.in_valid        (in_valid),
		.in_cmd          (in_cmd),
		.in_lane         (in_lane),
		.in_data         (in_data),
		.job_start       (job_start),
		.job_reads       (job_reads),
		.job_writes      (job_writes),
		.lane_data       (lane_data),
		.lane_data_valid (lane_data_valid),
		.lane_write_error(lane_write_error),
		.lane_job_done   (lane_job_done),
		.drop_count      (drop_count)
	);

	always #20 clock = ~clock;

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	assign beat_legal = in_valid && ((in_cmd == CMD_READ) || (in_cmd == CMD_WRITE))
		&& (int'(in_lane) < LANES);

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int s = 0; s < READ_STAGES; s++) begin
				rd_valid[s] <= 1'b0;
				rd_lane[s]  <= '0;
				rd_data[s]  <= '0;
			end
			for (int s = 0; s < 2; s++) begin
				wr_valid[s] <= 1'b0;
				wr_lane[s]  <= '0;
				wr_bad[s]   <= 1'b0;
			end
			exp_drops <= '0;
			for (int l = 0; l < LANES; l++) begin
				exp_err[l]     <= 1'b0;
				job_active[l]  <= 1'b0;
				goal_reads[l]  <= '0;
				goal_writes[l] <= '0;
				rd_seen[l]     <= 0;
				wr_seen[l]     <= 0;
				done_due[l]    <= 1'b0;
				done_given[l]  <= 1'b0;
			end
		end else begin
			// Read beats travel four registers
			rd_valid[0] <= beat_legal && (in_cmd == CMD_READ);
			rd_lane[0]  <= in_lane;
			rd_data[0]  <= in_data;
			for (int s = 1; s < READ_STAGES; s++) begin
				rd_valid[s] <= rd_valid[s-1];
				rd_lane[s]  <= rd_lane[s-1];
				rd_data[s]  <= rd_data[s-1];
			end
			// Write completions travel two
			wr_valid[0] <= beat_legal && (in_cmd == CMD_WRITE);
			wr_lane[0]  <= in_lane;
			wr_bad[0]   <= in_data[STATUS_WIDTH-1:0] != STATUS_OK;
			wr_valid[1] <= wr_valid[0];
			wr_lane[1]  <= wr_lane[0];
			wr_bad[1]   <= wr_bad[0];
			if (in_valid && !beat_legal && (exp_drops != {CNT_WIDTH{1'b1}})) begin
				exp_drops <= exp_drops + 1'b1;
			end
			for (int l = 0; l < LANES; l++) begin
				// Failing write wins over a start in the same cycle
				if (wr_valid[0] && wr_bad[0] && (wr_lane[0] == LANE_WIDTH'(l))) begin
					exp_err[l] <= 1'b1;
				end else if (job_start[l]) begin
					exp_err[l] <= 1'b0;
				end
				if (job_start[l]) begin
					job_active[l]  <= 1'b1;
					goal_reads[l]  <= job_reads[l];
					goal_writes[l] <= job_writes[l];
					rd_seen[l]     <= 0;
					wr_seen[l]     <= 0;
					done_due[l]    <= 1'b0;
					done_given[l]  <= 1'b0;
				end else begin
					if (rd_valid[READ_STAGES-1]
							&& (rd_lane[READ_STAGES-1] == LANE_WIDTH'(l))) begin
						rd_seen[l] <= rd_seen[l] + 1;
					end
					if (wr_valid[1] && (wr_lane[1] == LANE_WIDTH'(l))) begin
						wr_seen[l] <= wr_seen[l] + 1;
					end
					// Done is due the cycle after both counts are reached
					done_due[l] <= job_active[l] && (rd_seen[l] >= int'(goal_reads[l]))
						&& (wr_seen[l] >= int'(goal_writes[l]));
					// Only one pulse per job
					if (done_due[l] && !done_given[l]) begin
						done_given[l] <= 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		exp_valid_vec = '0;
		exp_ack_vec   = '0;
		if (rd_valid[READ_STAGES-1]) begin
			exp_valid_vec[rd_lane[READ_STAGES-1]] = 1'b1;
		end
		if (wr_valid[1]) begin
			exp_ack_vec[wr_lane[1]] = 1'b1;
		end
		for (int l = 0; l < LANES; l++) begin
			valid_vec[l]    = lane_data_valid[l];
			ack_vec[l]      = u_response_steering_top.ack_pulse[l];
			err_vec[l]      = lane_write_error[l];
			exp_err_vec[l]  = exp_err[l];
			done_vec[l]     = lane_job_done[l];
			exp_done_vec[l] = done_due[l] && !done_given[l];
		end
	end

	// ----------------------------------------
	// Checks, sampled mid-cycle
	// ----------------------------------------

	task automatic note_mismatch(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		value_errors++;
		$display("ERROR [%s] %s: expected %0h actual %0h", test_name, what, expected, actual);
	endtask

	assert property (@(negedge clock) valid_vec == exp_valid_vec)
		else note_mismatch("lane valid", 64'(exp_valid_vec), 64'(valid_vec));
	assert property (@(negedge clock)
			!rd_valid[READ_STAGES-1]
			|| (lane_data[rd_lane[READ_STAGES-1]] == rd_data[READ_STAGES-1]))
		else note_mismatch("lane data", 64'(rd_data[READ_STAGES-1]),
			64'(lane_data[rd_lane[READ_STAGES-1]]));
	assert property (@(negedge clock) ack_vec == exp_ack_vec)
		else note_mismatch("write ack", 64'(exp_ack_vec), 64'(ack_vec));
	assert property (@(negedge clock) err_vec == exp_err_vec)
		else note_mismatch("write error", 64'(exp_err_vec), 64'(err_vec));
	assert property (@(negedge clock) drop_count == exp_drops)
		else note_mismatch("drop count", 64'(exp_drops), 64'(drop_count));
	assert property (@(negedge clock) done_vec == exp_done_vec)
		else note_mismatch("job done", 64'(exp_done_vec), 64'(done_vec));

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Inputs change a little after the rising edge
	task automatic tick();
		@(posedge clock);
		#2;
	endtask

	task automatic idle(input int cycles);
		in_valid = 1'b0;
		repeat (cycles) tick();
	endtask

	task automatic send_beat(input rsp_cmd_t cmd, input int lane,
			input logic [DATA_WIDTH-1:0] data);
		in_valid = 1'b1;
		in_cmd   = cmd;
		in_lane  = LANE_WIDTH'(lane);
		in_data  = data;
		tick();
		in_valid = 1'b0;
	endtask

	function automatic logic [DATA_WIDTH-1:0] status_word(input bit bad);
		logic [DATA_WIDTH-1:0] word;
		word = $random(seed);
		word[STATUS_WIDTH-1:0] = bad ? STATUS_WIDTH'(1 + rand_below(15)) : STATUS_OK;
		return word;
	endfunction

	task automatic start_job(input int lane, input int reads, input int writes);
		job_start[lane]  = 1'b1;
		job_reads[lane]  = CNT_WIDTH'(reads);
		job_writes[lane] = CNT_WIDTH'(writes);
		tick();
		job_start[lane] = 1'b0;
	endtask

	task automatic wait_job_done(input int lane, input int limit);
		int cycles;
		bit seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && (cycles < limit)) begin
			@(negedge clock);
			seen = lane_job_done[lane];
			cycles++;
		end
		if (!seen) begin
			timeout_errors++;
			$display("timeout waiting for lane job done on lane %0d", lane);
		end
		tick();
	endtask

	// Reads and writes in random order with random gaps
	task automatic run_job(input int lane, input int reads, input int writes);
		int r;
		int w;
		r = reads;
		w = writes;
		start_job(lane, reads, writes);
		while ((r + w) > 0) begin
			if ((w == 0) || ((r > 0) && (rand_below(2) == 0))) begin
				send_beat(CMD_READ, lane, $random(seed));
				r--;
			end else begin
				send_beat(CMD_WRITE, lane, status_word(1'b0));
				w--;
			end
			idle(rand_below(3));
		end
		wait_job_done(lane, JOB_LIMIT);
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial begin
		int lane;
		int prev_lane;
		seed           = 32'hcd34_2a0b;
		value_errors   = 0;
		timeout_errors = 0;
		clock    = 1'b0;
		rstn     = 1'b0;
		in_valid = 1'b0;
		in_cmd   = CMD_NONE;
		in_lane  = '0;
		in_data  = '0;
		for (int l = 0; l < LANES; l++) begin
			job_start[l]  = 1'b0;
			job_reads[l]  = '0;
			job_writes[l] = '0;
		end

		test_name = "reset";
		repeat (10) @(posedge clock);
		#2;
		rstn = 1'b1;
		idle(4);

		// Mostly back-to-back and never the same lane twice in a row
		test_name = "read steering";
		prev_lane = 0;
		repeat (40) begin
			lane = (prev_lane + 1 + rand_below(LANES - 1)) % LANES;
			send_beat(CMD_READ, lane, $random(seed));
			prev_lane = lane;
			if (rand_below(4) == 0) begin
				idle(rand_below(3));
			end
		end
		idle(READ_STAGES + 2);

		// Bad opcodes and lanes past the last engine mixed with good reads
		test_name = "drops";
		repeat (24) begin
			case (rand_below(5))
				0: send_beat(CMD_NONE, rand_below(LANES), $random(seed));
				1: send_beat(CMD_RSVD, rand_below(LANES), $random(seed));
				2: send_beat(CMD_READ, LANES + rand_below(8 - LANES), $random(seed));
				3: send_beat(CMD_WRITE, LANES + rand_below(8 - LANES), status_word(1'b1));
				default: send_beat(CMD_READ, rand_below(LANES), $random(seed));
			endcase
		end
		idle(READ_STAGES + 2);

		test_name = "write errors";
		for (int l = 0; l < LANES; l++) begin
			send_beat(CMD_WRITE, l, status_word(1'b0));
		end
		send_beat(CMD_WRITE, 2, status_word(1'b1));
		idle(3);
		send_beat(CMD_WRITE, 4, status_word(1'b1));
		idle(5);
		// Zero-size job clears the flag and closes at once
		start_job(2, 0, 0);
		wait_job_done(2, ZERO_LIMIT);
		idle(4);

		test_name = "job completion";
		run_job(4, 3, 2);
		idle(3);
		repeat (6) begin
			run_job(rand_below(LANES), 1 + rand_below(5), rand_below(5));
			idle(rand_below(4));
		end
		start_job(0, 0, 0);
		wait_job_done(0, ZERO_LIMIT);
		idle(8);

		$display("errors: value %0d timeout %0d", value_errors, timeout_errors);
		if ((value_errors == 0) && (timeout_errors == 0)) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- write_ack_collector.sv
/* Write completion collector
   Per-lane ack pulses and sticky error flags from write completions */

module write_ack_collector import accel_cfg_pkg::*, rsp_types_pkg::*; #(
	parameter int LANES      = DEF_LANES,
	parameter int DATA_WIDTH = DEF_DATA_WIDTH
) (
	input  logic clock,
	input  logic rstn,
	rsp_if.sink  rsp,
	input  logic job_start   [0:LANES-1],
	output logic ack_pulse   [0:LANES-1],
	output logic write_error [0:LANES-1]
);

	localparam int LANE_WIDTH = $clog2(LANES);

	logic                    write_beat;
	logic [DATA_WIDTH-1:0]   beat_data;
	logic [STATUS_WIDTH-1:0] beat_status;
	logic                    status_bad;

	// ----------------------------------------
	// Completion decode
	// ----------------------------------------

	assign write_beat = rsp.valid && (rsp.cmd == CMD_WRITE);

	// Status lives in the low bits of the completion word
	assign beat_data   = rsp.data;
	assign beat_status = beat_data[STATUS_WIDTH-1:0];
	assign status_bad  = beat_status != STATUS_OK;

	// ----------------------------------------
	// Per-lane ack and error
	// ----------------------------------------

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		logic lane_hit;

		assign lane_hit = write_beat && (rsp.lane == LANE_WIDTH'(i));

		// One cycle pulse per completion
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				ack_pulse[i] <= 1'b0;
			end else begin
				ack_pulse[i] <= lane_hit;
			end
		end

		// Sticky until the lane starts a new job
		// A failing write in the start cycle still sets it
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				write_error[i] <= 1'b0;
			end else if (lane_hit && status_bad) begin
				write_error[i] <= 1'b1;
			end else if (job_start[i]) begin
				write_error[i] <= 1'b0;
			end
		end
	end

endmodule
